// File: Bender.yml
package:
  name: memory_update

sources:
  # RTL
  - files:
      - hdl/ntm_num_pkg.sv
      - hdl/ntm_ctrl_pkg.sv
      - hdl/elem_if.sv
      - hdl/update_controller.sv
      - hdl/index_counter.sv
      - hdl/vector_store.sv
      - hdl/element_update_pipe.sv
      - hdl/memory_update_top.sv
  # Testbench
  - target: test
    files:
      - test/memory_update_assertions.sv
      - test/tb_memory_update.sv

// File: all.f
hdl/ntm_num_pkg.sv
hdl/ntm_ctrl_pkg.sv
hdl/elem_if.sv
hdl/update_controller.sv
hdl/index_counter.sv
hdl/vector_store.sv
hdl/element_update_pipe.sv
hdl/memory_update_top.sv
test/memory_update_assertions.sv
test/tb_memory_update.sv

// File: hdl/elem_if.sv
// Element interface between controller, vector store and update pipeline
// Carries one matrix element with its operands, plus the pipeline feedback

`timescale 1ns/10ps

interface elem_if;

  // Element qualifier and end of matrix marker
  logic valid;
  logic last;

  // Old matrix element
  logic signed [ntm_num_pkg::DATA_W-1:0] m;

  // Operands for this element, w(j), e(k) and v(k)
  logic signed [ntm_num_pkg::DATA_W-1:0] w;
  logic signed [ntm_num_pkg::DATA_W-1:0] e;
  logic signed [ntm_num_pkg::DATA_W-1:0] v;

  // Pipeline output is blocked
  logic stall;
  // Element at the pipeline output is the last of the matrix
  logic out_last;

  // Controller drives valid, last and m, store drives the operands
  modport src (output valid, last, m, w, e, v, input stall, out_last);
  modport sink (input valid, last, m, w, e, v, output stall, out_last);

endinterface

// File: hdl/element_update_pipe.sv
// Three-stage fixed-point element update pipeline
// m * (1 - w*e) + w*v with truncating products and a saturated sum

`timescale 1ns/10ps

module element_update_pipe (
  input  logic                                  CLK,
  input  logic                                  RST,
  elem_if.sink                                  elem,
  output logic                                  m_out_valid,
  output logic signed [ntm_num_pkg::DATA_W-1:0] m_out,
  input  logic                                  m_out_ready
);

  logic advance;

  // Products widen, only the final sum is saturated
  logic signed [2*ntm_num_pkg::DATA_W-1:0] we_full, wv_full, keep;
  logic signed [3*ntm_num_pkg::DATA_W-1:0] mk_full, sum;
  logic signed [ntm_num_pkg::DATA_W-1:0]   sat;

  logic                                    s1_valid, s2_valid, s3_valid;
  logic                                    s1_last, s2_last, s3_last;
  logic signed [ntm_num_pkg::DATA_W-1:0]   s1_m;
  logic signed [2*ntm_num_pkg::DATA_W-1:0] s1_we, s1_wv, s2_wv;
  logic signed [3*ntm_num_pkg::DATA_W-1:0] s2_mk;
  logic signed [ntm_num_pkg::DATA_W-1:0]   s3_data;

  // Output held and not taken, so everything freezes
  assign elem.stall    = s3_valid && !m_out_ready;
  assign elem.out_last = s3_last;
  assign advance       = !elem.stall;

  ////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////

  // Stage 1 inputs
  assign we_full = elem.w * elem.e;
  assign wv_full = elem.w * elem.v;

  // Stage 2 inputs, arithmetic shift rounds toward minus infinity
  assign keep    = ntm_num_pkg::ONE_FX - s1_we;
  assign mk_full = keep * s1_m;

  // Stage 3 inputs
  assign sum = s2_mk + s2_wv;

  always_comb begin
    if (sum > ntm_num_pkg::DATA_MAX) sat = ntm_num_pkg::DATA_MAX;
    else if (sum < ntm_num_pkg::DATA_MIN) sat = ntm_num_pkg::DATA_MIN;
    else sat = sum[ntm_num_pkg::DATA_W-1:0];
  end

  always_ff @(posedge CLK) begin
    if (advance) begin
      s1_m    <= elem.m;
      s1_we   <= we_full >>> ntm_num_pkg::FRAC_W;
      s1_wv   <= wv_full >>> ntm_num_pkg::FRAC_W;
      s2_mk   <= mk_full >>> ntm_num_pkg::FRAC_W;
      s2_wv   <= s1_wv;
      s3_data <= sat;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Valid and last tracking
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      {s1_valid, s2_valid, s3_valid} <= 3'b000;
      {s1_last, s2_last, s3_last}    <= 3'b000;
    end else if (advance) begin
      s1_valid <= elem.valid;
      s2_valid <= s1_valid;
      s3_valid <= s2_valid;
      // Last only counts on a real element
      s1_last  <= elem.valid && elem.last;
      s2_last  <= s1_last;
      s3_last  <= s2_last;
    end
  end

  assign m_out_valid = s3_valid;
  assign m_out       = s3_data;

endmodule

// File: hdl/index_counter.sv
// Row and column index counter
// Row-major walk with programmable limits and end flags

`timescale 1ns/10ps

module index_counter (
  input  logic                           CLK,
  input  logic                           RST,
  input  logic                           clear,
  input  logic                           step,
  input  logic [ntm_num_pkg::SIZE_W-1:0] limit_j,
  input  logic [ntm_num_pkg::SIZE_W-1:0] limit_k,
  output logic [ntm_num_pkg::IDX_W-1:0]  j,
  output logic [ntm_num_pkg::IDX_W-1:0]  k,
  output logic                           wrap_k,
  output logic                           last
);

  // Column at its limit, and whole matrix at its end
  assign wrap_k = ({1'b0, k} == limit_k - 1'b1);
  assign last   = wrap_k && ({1'b0, j} == limit_j - 1'b1);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      j <= '0;
      k <= '0;
    end else if (clear) begin
      j <= '0;
      k <= '0;
    end else if (step) begin
      if (wrap_k) begin
        k <= '0;
        // Row wraps too at the end, ready for the next phase
        j <= last ? '0 : j + 1'b1;
      end else begin
        k <= k + 1'b1;
      end
    end
  end

endmodule

// File: hdl/memory_update_top.sv
// Top level of the memory matrix update engine
// Controller, index counter, vector store and update pipeline

`timescale 1ns/10ps

module memory_update_top (
  input  logic                                  CLK,
  input  logic                                  RST,
  input  logic        [ntm_num_pkg::SIZE_W-1:0] size_n,
  input  logic        [ntm_num_pkg::SIZE_W-1:0] size_w,
  input  logic                                  vec_valid,
  input  logic signed [ntm_num_pkg::DATA_W-1:0] vec_data,
  output logic                                  vec_ready,
  input  logic                                  m_in_valid,
  input  logic signed [ntm_num_pkg::DATA_W-1:0] m_in,
  output logic                                  m_in_ready,
  output logic                                  m_out_valid,
  output logic signed [ntm_num_pkg::DATA_W-1:0] m_out,
  input  logic                                  m_out_ready,
  input  logic                                  start,
  output logic                                  busy,
  output logic                                  done
);

  logic                           cnt_step, cnt_clear, cnt_wrap_k, cnt_last;
  logic [ntm_num_pkg::SIZE_W-1:0] limit_j, limit_k;
  logic [ntm_num_pkg::IDX_W-1:0]  j, k;
  logic                           vec_wr;
  logic [2:0]                     vec_sel;

  // Element and operands into the pipeline
  elem_if elem_i ();

  update_controller update_controller_i (
    .CLK        (CLK),
    .RST        (RST),
    .start      (start),
    .size_n     (size_n),
    .size_w     (size_w),
    .vec_valid  (vec_valid),
    .vec_ready  (vec_ready),
    .m_in_valid (m_in_valid),
    .m_in       (m_in),
    .m_in_ready (m_in_ready),
    .m_out_valid(m_out_valid),
    .m_out_ready(m_out_ready),
    .busy       (busy),
    .done       (done),
    .cnt_step   (cnt_step),
    .cnt_clear  (cnt_clear),
    .limit_j    (limit_j),
    .limit_k    (limit_k),
    .cnt_wrap_k (cnt_wrap_k),
    .cnt_last   (cnt_last),
    .vec_wr     (vec_wr),
    .vec_sel    (vec_sel),
    .elem       (elem_i.src)
  );

  index_counter index_counter_i (
    .CLK    (CLK),
    .RST    (RST),
    .clear  (cnt_clear),
    .step   (cnt_step),
    .limit_j(limit_j),
    .limit_k(limit_k),
    .j      (j),
    .k      (k),
    .wrap_k (cnt_wrap_k),
    .last   (cnt_last)
  );

  // Loads write at k, updates read w at j and e, v at k
  vector_store vector_store_i (
    .CLK    (CLK),
    .RST    (RST),
    .wr     (vec_wr),
    .sel    (vec_sel),
    .wr_idx (k),
    .wr_data(vec_data),
    .rd_j   (j),
    .rd_k   (k),
    .elem   (elem_i.src)
  );

  element_update_pipe element_update_pipe_i (
    .CLK        (CLK),
    .RST        (RST),
    .elem       (elem_i.sink),
    .m_out_valid(m_out_valid),
    .m_out      (m_out),
    .m_out_ready(m_out_ready)
  );

endmodule

// File: hdl/ntm_ctrl_pkg.sv
// Control definitions of the memory update engine
// Controller state encoding

package ntm_ctrl_pkg;

  // Phases of one update run
  typedef enum logic [2:0] {
    // Waiting for start
    ST_IDLE   = 3'd0,
    // Loading write weighting, one per row
    ST_LOAD_W = 3'd1,
    // Loading erase vector, one per column
    ST_LOAD_E = 3'd2,
    // Loading add vector, one per column
    ST_LOAD_V = 3'd3,
    // Streaming the old matrix in
    ST_UPDATE = 3'd4,
    // Waiting for the pipeline to empty
    ST_DRAIN  = 3'd5
  } update_state_e;

endpackage

// File: hdl/ntm_num_pkg.sv
// Number format of the memory update engine
// Fixed-point widths, constants and matrix size limits

package ntm_num_pkg;

  ////////////////////////////////////////////////////////////////////
  // Fixed-point format
  ////////////////////////////////////////////////////////////////////

  // Signed Q3.12 elements
  localparam int DATA_W = 16;
  localparam int FRAC_W = 12;

  // 1.0 in Q3.12
  localparam logic signed [DATA_W-1:0] ONE_FX = DATA_W'(1 << FRAC_W);

  // Saturation limits of the final sum
  localparam logic signed [DATA_W-1:0] DATA_MAX = {1'b0, {(DATA_W-1){1'b1}}};
  localparam logic signed [DATA_W-1:0] DATA_MIN = {1'b1, {(DATA_W-1){1'b0}}};

  ////////////////////////////////////////////////////////////////////
  // Matrix size limits
  ////////////////////////////////////////////////////////////////////

  localparam int N_MAX  = 8;
  localparam int W_MAX  = 8;
  localparam int IDX_W  = 3;
  // Sizes run 1 to 8, so one bit more than an index
  localparam int SIZE_W = 4;

endpackage

// File: hdl/update_controller.sv
// Phase controller of the memory update engine
// Load and update FSM, stream handshakes, counter and store control

`timescale 1ns/10ps

module update_controller (
  input  logic                                  CLK,
  input  logic                                  RST,
  input  logic                                  start,
  input  logic        [ntm_num_pkg::SIZE_W-1:0] size_n,
  input  logic        [ntm_num_pkg::SIZE_W-1:0] size_w,
  input  logic                                  vec_valid,
  output logic                                  vec_ready,
  input  logic                                  m_in_valid,
  input  logic signed [ntm_num_pkg::DATA_W-1:0] m_in,
  output logic                                  m_in_ready,
  input  logic                                  m_out_valid,
  input  logic                                  m_out_ready,
  output logic                                  busy,
  output logic                                  done,
  output logic                                  cnt_step,
  output logic                                  cnt_clear,
  output logic        [ntm_num_pkg::SIZE_W-1:0] limit_j,
  output logic        [ntm_num_pkg::SIZE_W-1:0] limit_k,
  input  logic                                  cnt_wrap_k,
  input  logic                                  cnt_last,
  output logic                                  vec_wr,
  output logic        [2:0]                     vec_sel,
  elem_if.src                                   elem
);

  ntm_ctrl_pkg::update_state_e state;
  ntm_ctrl_pkg::update_state_e state_nxt;

  logic vec_xfer;
  logic in_xfer;
  logic last_out_xfer;

  ////////////////////////////////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////////////////////////////////

  // One-hot vector select, bit 0 is w, bit 1 is e, bit 2 is v
  assign vec_sel[0] = (state == ntm_ctrl_pkg::ST_LOAD_W);
  assign vec_sel[1] = (state == ntm_ctrl_pkg::ST_LOAD_E);
  assign vec_sel[2] = (state == ntm_ctrl_pkg::ST_LOAD_V);

  assign vec_ready  = |vec_sel;
  assign m_in_ready = (state == ntm_ctrl_pkg::ST_UPDATE) && !elem.stall;

  assign vec_xfer = vec_valid && vec_ready;
  assign in_xfer  = m_in_valid && m_in_ready;
  // Last matrix element leaving the pipeline
  assign last_out_xfer = (state == ntm_ctrl_pkg::ST_DRAIN) && m_out_valid &&
                         m_out_ready && elem.out_last;

  assign busy = (state != ntm_ctrl_pkg::ST_IDLE);

  // Element into the pipeline, operands come from the store
  assign elem.valid = in_xfer;
  assign elem.m     = m_in;
  assign elem.last  = cnt_last;

  ////////////////////////////////////////////////////////////////////
  // Counter and store control
  ////////////////////////////////////////////////////////////////////

  assign cnt_step  = vec_xfer || in_xfer;
  assign cnt_clear = (state == ntm_ctrl_pkg::ST_IDLE) && start;
  assign vec_wr    = vec_xfer;

  // Loads walk k only, update walks the full matrix
  always_comb begin
    limit_j = {{(ntm_num_pkg::SIZE_W-1){1'b0}}, 1'b1};
    limit_k = size_w;
    case (state)
      ntm_ctrl_pkg::ST_LOAD_W: limit_k = size_n;
      ntm_ctrl_pkg::ST_UPDATE: limit_j = size_n;
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      ntm_ctrl_pkg::ST_IDLE:   if (start) state_nxt = ntm_ctrl_pkg::ST_LOAD_W;
      ntm_ctrl_pkg::ST_LOAD_W: if (vec_xfer && cnt_wrap_k) state_nxt = ntm_ctrl_pkg::ST_LOAD_E;
      ntm_ctrl_pkg::ST_LOAD_E: if (vec_xfer && cnt_wrap_k) state_nxt = ntm_ctrl_pkg::ST_LOAD_V;
      ntm_ctrl_pkg::ST_LOAD_V: if (vec_xfer && cnt_wrap_k) state_nxt = ntm_ctrl_pkg::ST_UPDATE;
      ntm_ctrl_pkg::ST_UPDATE: if (in_xfer && cnt_last) state_nxt = ntm_ctrl_pkg::ST_DRAIN;
      ntm_ctrl_pkg::ST_DRAIN:  if (last_out_xfer) state_nxt = ntm_ctrl_pkg::ST_IDLE;
      default:                 state_nxt = ntm_ctrl_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= ntm_ctrl_pkg::ST_IDLE;
      done  <= 1'b0;
    end else begin
      state <= state_nxt;
      // Single cycle, together with the return to idle
      done  <= last_out_xfer;
    end
  end

endmodule

// File: hdl/vector_store.sv
// Operand store for the write weighting, erase and add vectors
// Indexed write from the vector stream, combinational read per element

`timescale 1ns/10ps

module vector_store (
  input  logic                                  CLK,
  input  logic                                  RST,
  input  logic                                  wr,
  input  logic        [2:0]                     sel,
  input  logic        [ntm_num_pkg::IDX_W-1:0]  wr_idx,
  input  logic signed [ntm_num_pkg::DATA_W-1:0] wr_data,
  input  logic        [ntm_num_pkg::IDX_W-1:0]  rd_j,
  input  logic        [ntm_num_pkg::IDX_W-1:0]  rd_k,
  elem_if.src                                   elem
);

  // w over rows, e and v over columns
  logic signed [ntm_num_pkg::DATA_W-1:0] w_mem [ntm_num_pkg::N_MAX];
  logic signed [ntm_num_pkg::DATA_W-1:0] e_mem [ntm_num_pkg::W_MAX];
  logic signed [ntm_num_pkg::DATA_W-1:0] v_mem [ntm_num_pkg::W_MAX];

  // Select is one-hot from the controller state
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int i = 0; i < ntm_num_pkg::N_MAX; i++) begin
        w_mem[i] <= '0;
      end
      for (int i = 0; i < ntm_num_pkg::W_MAX; i++) begin
        e_mem[i] <= '0;
        v_mem[i] <= '0;
      end
    end else if (wr) begin
      if (sel[0]) w_mem[wr_idx] <= wr_data;
      if (sel[1]) e_mem[wr_idx] <= wr_data;
      if (sel[2]) v_mem[wr_idx] <= wr_data;
    end
  end

  // Operands for the element at (j, k)
  assign elem.w = w_mem[rd_j];
  assign elem.e = e_mem[rd_k];
  assign elem.v = v_mem[rd_k];

endmodule

// File: test/memory_update_assertions.sv
// Protocol assertions for the memory update engine
// Stream stability, done pulse width and load/update exclusion

`timescale 1ns/10ps

module memory_update_assertions (
  input logic                              CLK,
  input logic                              RST,
  input logic                              vec_valid,
  input logic                              vec_ready,
  input logic [ntm_num_pkg::DATA_W-1:0]    vec_data,
  input logic                              m_out_valid,
  input logic                              m_out_ready,
  input logic [ntm_num_pkg::DATA_W-1:0]    m_out,
  input logic                              done,
  input ntm_ctrl_pkg::update_state_e       state
);

  // Number of failed assertions
  int error_count = 0;

  // Offered vector element stays put until taken
  vec_stable_a: assert property (@(posedge CLK) disable iff (RST)
    vec_valid && !vec_ready |=> vec_valid && $stable(vec_data))
    else begin
      $error("vec_data changed or vec_valid dropped before transfer");
      error_count++;
    end

  // Pipeline output holds while blocked
  out_stable_a: assert property (@(posedge CLK) disable iff (RST)
    m_out_valid && !m_out_ready |=> m_out_valid && $stable(m_out))
    else begin
      $error("m_out changed or m_out_valid dropped before transfer");
      error_count++;
    end

  done_pulse_a: assert property (@(posedge CLK) disable iff (RST) done |=> !done)
    else begin
      $error("done stayed high for more than one cycle");
      error_count++;
    end

  // No vector loads while the matrix streams
  no_load_in_update_a: assert property (@(posedge CLK) disable iff (RST)
    state == ntm_ctrl_pkg::ST_UPDATE |-> !vec_ready)
    else begin
      $error("vec_ready high in update phase");
      error_count++;
    end

endmodule

bind memory_update_top memory_update_assertions memory_update_assertions_i (
  .CLK        (CLK),
  .RST        (RST),
  .vec_valid  (vec_valid),
  .vec_ready  (vec_ready),
  .vec_data   (vec_data),
  .m_out_valid(m_out_valid),
  .m_out_ready(m_out_ready),
  .m_out      (m_out),
  .done       (done),
  .state      (update_controller_i.state)
);

// File: test/tb_memory_update.sv
// Directed testbench for the memory update engine
// Clock and reset, stream drivers, reference model and test tasks

`timescale 1ns/10ps

module tb_memory_update;

  localparam int TIMEOUT_CYCLES = 200;

  logic                                  CLK = 1'b0;
  logic                                  RST;
  logic        [ntm_num_pkg::SIZE_W-1:0] size_n, size_w;
  logic                                  vec_valid, m_in_valid, m_out_ready, start;
  logic signed [ntm_num_pkg::DATA_W-1:0] vec_data, m_in;
  logic                                  vec_ready, m_in_ready, m_out_valid, busy, done;
  logic signed [ntm_num_pkg::DATA_W-1:0] m_out;

  // Operands and matrix of the current run
  logic signed [ntm_num_pkg::DATA_W-1:0] w_arr [ntm_num_pkg::N_MAX];
  logic signed [ntm_num_pkg::DATA_W-1:0] e_arr [ntm_num_pkg::W_MAX];
  logic signed [ntm_num_pkg::DATA_W-1:0] v_arr [ntm_num_pkg::W_MAX];
  logic signed [ntm_num_pkg::DATA_W-1:0] m_arr [ntm_num_pkg::N_MAX*ntm_num_pkg::W_MAX];
  logic signed [ntm_num_pkg::DATA_W-1:0] exp_q[$];
  logic signed [ntm_num_pkg::DATA_W-1:0] got_q[$];

  memory_update_top memory_update_top_i (
    .CLK(CLK), .RST(RST), .size_n(size_n), .size_w(size_w),
    .vec_valid(vec_valid), .vec_data(vec_data), .vec_ready(vec_ready),
    .m_in_valid(m_in_valid), .m_in(m_in), .m_in_ready(m_in_ready),
    .m_out_valid(m_out_valid), .m_out(m_out), .m_out_ready(m_out_ready),
    .start(start), .busy(busy), .done(done)
  );

  initial begin
    forever #2 CLK = ~CLK;
  end

  //////////////////////////////////////////////////////////////////////
  // Checking and reference
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [ntm_num_pkg::DATA_W-1:0] got,
                             input logic [ntm_num_pkg::DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: %s", what);
    abort_run();
  endtask

  // Protocol checker bound into the DUT
  always @(negedge CLK) begin
    if (memory_update_top_i.memory_update_assertions_i.error_count != 0) begin
      $display("A protocol assertion on the DUT ports failed");
      abort_run();
    end
  end

  // m * (1 - w*e) + w*v, products floored by the shift, sum saturated
  function automatic logic signed [ntm_num_pkg::DATA_W-1:0] ref_update(
      input logic signed [ntm_num_pkg::DATA_W-1:0] m, w, e, v);
    longint we, wv, mk, sum;
    we  = (longint'(w) * longint'(e)) >>> ntm_num_pkg::FRAC_W;
    wv  = (longint'(w) * longint'(v)) >>> ntm_num_pkg::FRAC_W;
    mk  = (((longint'(1) <<< ntm_num_pkg::FRAC_W) - we) * longint'(m)) >>> ntm_num_pkg::FRAC_W;
    sum = mk + wv;
    if (sum > longint'(ntm_num_pkg::DATA_MAX)) return ntm_num_pkg::DATA_MAX;
    if (sum < longint'(ntm_num_pkg::DATA_MIN)) return ntm_num_pkg::DATA_MIN;
    return sum[ntm_num_pkg::DATA_W-1:0];
  endfunction

  function automatic logic signed [ntm_num_pkg::DATA_W-1:0] rand_data();
    logic [31:0] r;
    r = $urandom;
    return r[ntm_num_pkg::DATA_W-1:0];
  endfunction

  task automatic fill_random(input int n, input int wc);
    for (int i = 0; i < n; i++) w_arr[i] = rand_data();
    for (int i = 0; i < wc; i++) begin
      e_arr[i] = rand_data();
      v_arr[i] = rand_data();
    end
    for (int i = 0; i < n * wc; i++) m_arr[i] = rand_data();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stream drivers, all entered and left on a falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic send_vectors(input logic signed [ntm_num_pkg::DATA_W-1:0] vals[$]);
    int wait_cnt;
    foreach (vals[i]) begin
      vec_valid = 1'b1;
      vec_data  = vals[i];
      wait_cnt  = 0;
      #1;
      while (!vec_ready) begin
        wait_cnt++;
        if (wait_cnt > TIMEOUT_CYCLES) report_timeout("vector stream never accepted an element");
        @(negedge CLK);
        #1;
      end
      @(negedge CLK);
    end
    vec_valid = 1'b0;
  endtask

  task automatic feed_matrix(input int total);
    int wait_cnt;
    for (int i = 0; i < total; i++) begin
      m_in_valid = 1'b1;
      m_in       = m_arr[i];
      wait_cnt   = 0;
      #1;
      while (!m_in_ready) begin
        wait_cnt++;
        if (wait_cnt > TIMEOUT_CYCLES) report_timeout("matrix input was never accepted");
        @(negedge CLK);
        #1;
      end
      @(negedge CLK);
    end
    m_in_valid = 1'b0;
  endtask

  // Random ready stretches when bp is set
  task automatic collect_matrix(input int total, input bit bp);
    int wait_cnt;
    int hold;
    wait_cnt = 0;
    hold     = 0;
    while (got_q.size() < total) begin
      if (bp) begin
        if (hold == 0) begin
          m_out_ready = $urandom_range(1, 0);
          hold        = $urandom_range(5, 1);
        end
        hold--;
      end else begin
        m_out_ready = 1'b1;
      end
      #1;
      check_value("done", done, 1'b0);
      if (m_out_valid && m_out_ready) begin
        check_value("m_out", m_out, exp_q[got_q.size()]);
        got_q.push_back(m_out);
        wait_cnt = 0;
      end else begin
        wait_cnt++;
        if (wait_cnt > TIMEOUT_CYCLES) report_timeout("updated matrix element never came out");
      end
      @(negedge CLK);
    end
    m_out_ready = 1'b0;
  endtask

  // Full run with the current arrays, expects to start on a falling edge
  task automatic run_update(input int n, input int wc, input bit bp);
    logic signed [ntm_num_pkg::DATA_W-1:0] vals[$];
    exp_q.delete();
    got_q.delete();
    for (int r = 0; r < n; r++) begin
      for (int c = 0; c < wc; c++) begin
        exp_q.push_back(ref_update(m_arr[r*wc+c], w_arr[r], e_arr[c], v_arr[c]));
      end
    end
    for (int i = 0; i < n; i++) vals.push_back(w_arr[i]);
    for (int i = 0; i < wc; i++) vals.push_back(e_arr[i]);
    for (int i = 0; i < wc; i++) vals.push_back(v_arr[i]);
    size_n    = n;
    size_w    = wc;
    // First w offered while still idle, held until the load opens
    vec_valid = 1'b1;
    vec_data  = vals[0];
    start     = 1'b1;
    @(negedge CLK);
    start = 1'b0;
    check_value("busy", busy, 1'b1);
    send_vectors(vals);
    fork
      feed_matrix(n * wc);
      collect_matrix(n * wc, bp);
    join
    // Done on the edge of the last output, then gone
    check_value("done", done, 1'b1);
    check_value("busy", busy, 1'b0);
    @(negedge CLK);
    check_value("done", done, 1'b0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset_idle();
    check_value("busy", busy, 1'b0);
    check_value("done", done, 1'b0);
    check_value("vec_ready", vec_ready, 1'b0);
    check_value("m_in_ready", m_in_ready, 1'b0);
    check_value("m_out_valid", m_out_valid, 1'b0);
  endtask

  task automatic test_plain_update();
    fill_random(4, 4);
    run_update(4, 4, 1'b0);
  endtask

  // Full erase and full write give v back
  task automatic test_edge_sizes();
    fill_random(1, 1);
    w_arr[0] = ntm_num_pkg::ONE_FX;
    e_arr[0] = ntm_num_pkg::ONE_FX;
    run_update(1, 1, 1'b0);
    check_value("m_out_erased", got_q[0], v_arr[0]);
    fill_random(8, 8);
    w_arr[0] = ntm_num_pkg::ONE_FX;
    e_arr[0] = ntm_num_pkg::ONE_FX;
    run_update(8, 8, 1'b0);
    check_value("m_out_erased", got_q[0], v_arr[0]);
  endtask

  // w*v of +-49 pushes the sum out of range in both directions
  task automatic test_saturation();
    for (int i = 0; i < 2; i++) begin
      w_arr[i] = 16'sh7000;
      e_arr[i] = '0;
    end
    v_arr[0] = 16'sh7000;
    v_arr[1] = 16'sh9000;
    for (int i = 0; i < 4; i++) m_arr[i] = 16'sh4000;
    run_update(2, 2, 1'b0);
    for (int i = 0; i < 4; i++) begin
      check_value("m_out_sat", got_q[i],
                  (i % 2 == 0) ? ntm_num_pkg::DATA_MAX : ntm_num_pkg::DATA_MIN);
    end
  endtask

  task automatic test_backpressure();
    fill_random(3, 5);
    run_update(3, 5, 1'b1);
  endtask

  // Second run starts on the cycle after done
  task automatic test_back_to_back();
    fill_random(2, 3);
    run_update(2, 3, 1'b0);
    fill_random(5, 2);
    run_update(5, 2, 1'b1);
  endtask

  initial begin
    void'($urandom(35659));
    RST         = 1'b1;
    start       = 1'b0;
    size_n      = '0;
    size_w      = '0;
    vec_valid   = 1'b0;
    vec_data    = '0;
    m_in_valid  = 1'b0;
    m_in        = '0;
    m_out_ready = 1'b0;
    repeat (3) @(negedge CLK);
    RST = 1'b0;
    test_reset_idle();
    test_plain_update();
    test_edge_sizes();
    test_saturation();
    test_backpressure();
    test_back_to_back();
    if (memory_update_top_i.memory_update_assertions_i.error_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
